//--- Makefile
# Verilator build and run for the processing element testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = pe_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- fifo_buffer.sv
module fifo_buffer #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             clear, // zero both counters
    input  logic             wen,
    input  logic             ren,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout, // head of buffer
    output logic             full,
    output logic             empty
);

    // one slot always left unused so full and empty can be told apart
    localparam int SLOTS  = DEPTH + 1;
    localparam int ADDR_W = $clog2(SLOTS);

    logic [WIDTH-1:0]  mem [SLOTS];
    logic [ADDR_W-1:0] waddr;
    logic [ADDR_W-1:0] raddr;
    logic [ADDR_W-1:0] waddr_next;
    logic [ADDR_W-1:0] raddr_next;
    logic              do_write;
    logic              do_read;

    // advance with wrap at the last slot
    function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] ptr);
        logic [ADDR_W-1:0] nxt;
        if (ptr == ADDR_W'(SLOTS - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign waddr_next = next_ptr(waddr);
    assign raddr_next = next_ptr(raddr);

    assign full  = (waddr_next == raddr); // writer one behind reader
    assign empty = (raddr == waddr);

    assign do_write = wen && !full;  // dropped when full
    assign do_read  = ren && !empty; // dropped when empty

    assign dout = mem[raddr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[waddr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            waddr <= '0;
            raddr <= '0;
        end else if (clear) begin
            waddr <= '0;
            raddr <= '0;
        end else begin
            if (do_write) begin
                waddr <= waddr_next;
            end
            if (do_read) begin
                raddr <= raddr_next;
            end
        end
    end

endmodule

//--- files.f
pe_cfg_pkg.sv
pe_ctrl_pkg.sv
fifo_buffer.sv
mac_unit.sv
psum_scratch_pad.sv
pe_controller.sv
pe_top.sv
pe_clock_gen.sv
pe_sva.sv
pe_tb.sv

//--- mac_unit.sv
module mac_unit (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              clear,
    input  logic                              issue,      // pair popped this cycle
    input  logic                              emit,       // last pair of an emit op
    input  logic [pe_cfg_pkg::DATA_WIDTH-1:0] weight,
    input  logic [pe_cfg_pkg::DATA_WIDTH-1:0] pixel,
    output logic [pe_cfg_pkg::PSUM_WIDTH-1:0] product,
    output logic                              prod_valid,
    output logic                              prod_emit
);

    import pe_cfg_pkg::*;

    logic signed [2*DATA_WIDTH-1:0] mult;

    assign mult = $signed(pixel) * $signed(weight); // full precision product

    always_ff @(posedge clk) begin
        if (!rstn) begin
            prod_valid <= 1'b0;
            prod_emit  <= 1'b0;
        end else if (clear) begin
            prod_valid <= 1'b0; // drop pending product
            prod_emit  <= 1'b0;
        end else begin
            prod_valid <= issue;
            prod_emit  <= issue && emit;
        end
    end

    // sign extend into psum width
    always_ff @(posedge clk) begin
        if (issue) begin
            product <= {{(PSUM_WIDTH - 2*DATA_WIDTH){mult[2*DATA_WIDTH-1]}}, mult};
        end
    end

endmodule

//--- pe_cfg_pkg.sv
package pe_cfg_pkg;

    // signed weight and pixel
    localparam int DATA_WIDTH = 8;

    // signed partial sum, wraps on overflow
    localparam int PSUM_WIDTH = 24;

    // taps per filter row
    // also the pops per operation and the filter buffer depth
    localparam int FILT_LEN = 3;

    localparam int IFMAP_DEPTH = 8; // pixel buffer depth

    localparam int PSUM_DEPTH = 4; // output psum buffer depth

    // tap counter width, covers 0 .. FILT_LEN
    localparam int TAP_WIDTH = $clog2(FILT_LEN + 1);

endpackage

//--- pe_clock_gen.sv
module pe_clock_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk; // 50% duty
    end

endmodule

//--- pe_controller.sv
module pe_controller (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              start,
    input  pe_ctrl_pkg::pe_op_t               op,
    input  logic                              ifmap_empty,
    input  logic                              psum_full,
    input  logic                              weight_wen,  // external weight load
    input  logic [pe_cfg_pkg::DATA_WIDTH-1:0] weight_din,
    input  logic [pe_cfg_pkg::DATA_WIDTH-1:0] filt_dout,   // filter buffer head
    output logic                              filt_wen,
    output logic [pe_cfg_pkg::DATA_WIDTH-1:0] filt_din,
    output logic                              filt_ren,
    output logic                              ifmap_ren,
    output logic                              issue,
    output logic                              emit,
    output logic                              busy,
    output logic                              done
);

    import pe_cfg_pkg::*;
    import pe_ctrl_pkg::*;

    pe_state_t             state;
    pe_state_t             state_next;
    pe_op_t                op_q;     // opcode latched at start
    logic [TAP_WIDTH-1:0]  tap_cnt;  // pairs issued so far
    logic                  last_tap;
    logic                  wb_valid; // weight popped last cycle
    logic [DATA_WIDTH-1:0] wb_data;

    assign issue     = (state == ST_MAC) && !ifmap_empty; // empty ifmap is a stall
    assign last_tap  = (tap_cnt == TAP_WIDTH'(FILT_LEN - 1));
    assign emit      = issue && last_tap && (op_q == OP_MAC_EMIT);
    assign filt_ren  = issue;
    assign ifmap_ren = issue;
    assign busy      = (state != ST_IDLE);
    assign done      = (state == ST_DONE);

    // the weight goes back one cycle after its pop, once its slot is free,
    // so the filter row keeps its order; the last one lands in ST_DONE
    assign filt_wen = busy ? wb_valid : weight_wen; // external load only when idle
    assign filt_din = busy ? wb_data : weight_din;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    if (op == OP_MAC_EMIT && psum_full) begin
                        state_next = ST_EMIT_WAIT; // no room for the result
                    end else begin
                        state_next = ST_MAC;
                    end
                end
            end
            ST_EMIT_WAIT: begin
                if (!psum_full) begin
                    state_next = ST_MAC;
                end
            end
            ST_MAC: begin
                if (issue && last_tap) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= ST_IDLE;
            op_q     <= OP_MAC;
            tap_cnt  <= '0;
            wb_valid <= 1'b0;
        end else begin
            state    <= state_next;
            wb_valid <= issue;
            if (state == ST_IDLE && start) begin
                op_q    <= op;
                tap_cnt <= '0;
            end else if (issue) begin
                tap_cnt <= last_tap ? '0 : tap_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            wb_data <= filt_dout; // weight to rewrite
        end
    end

endmodule

//--- pe_ctrl_pkg.sv
package pe_ctrl_pkg;

    // operation carried by the start strobe
    typedef enum logic [0:0] {
        OP_MAC      = 1'b0, // accumulate only
        OP_MAC_EMIT = 1'b1  // accumulate, then release psum
    } pe_op_t;

    // controller FSM
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0, // waiting for start
        ST_MAC       = 2'd1, // issuing pixel/weight pairs
        ST_EMIT_WAIT = 2'd2, // psum buffer full, hold off
        ST_DONE      = 2'd3  // one cycle, done pulse
    } pe_state_t;

endpackage

//--- pe_sva.sv
module pe_sva (
    input logic clk,
    input logic rstn,
    input logic start,
    input logic busy,
    input logic done
);

    done_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // done only ends an operation that was running
    done_after_busy: assert property (@(posedge clk) disable iff (!rstn)
        done |-> $past(busy))
        else $error("done rose without busy in the cycle before");

    idle_after_reset: assert property (@(posedge clk)
        !rstn |=> (!busy && !done))
        else $error("busy or done high right after reset");

    // an operation starts only from idle
    start_from_idle: assert property (@(posedge clk) disable iff (!rstn)
        $rose(busy) |-> $past(start && !busy))
        else $error("busy rose without a start taken while idle");

    done_returns_idle: assert property (@(posedge clk) disable iff (!rstn)
        done |=> !busy)
        else $error("controller did not return to idle after done");

endmodule

bind pe_top pe_sva u_sva (
    .clk  (clk),
    .rstn (rstn),
    .start(start),
    .busy (busy),
    .done (done)
);

//--- pe_tb.sv
module pe_tb;

    import pe_cfg_pkg::*;
    import pe_ctrl_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 10;
    localparam int DRIVE_DELAY   = 5;
    localparam int NUM_OPS       = 16; // operations issued by all tests together
    localparam int OP_CYCLES     = FILT_LEN + IFMAP_DEPTH + 20;
    localparam int WATCHDOG_TIME = NUM_OPS * OP_CYCLES * CLK_PERIOD
                                   + RESET_CYCLES * CLK_PERIOD;

    typedef logic signed [DATA_WIDTH-1:0] row_t [FILT_LEN];

    logic                  clk;
    logic                  rstn;
    logic                  clear;
    logic                  start;
    pe_op_t                op;
    logic                  weight_wen;
    logic [DATA_WIDTH-1:0] weight_din;
    logic                  weight_full;
    logic                  ifmap_wen;
    logic [DATA_WIDTH-1:0] ifmap_din;
    logic                  ifmap_full;
    logic                  psum_ren;
    logic [PSUM_WIDTH-1:0] psum_dout;
    logic                  psum_empty;
    logic                  busy;
    logic                  done;

    row_t                  weights;        // row held in the filter buffer
    row_t                  pixels;         // pixels of the current operation
    logic [PSUM_WIDTH-1:0] acc_model;      // running sum across OP_MAC
    logic [PSUM_WIDTH-1:0] expected [$];
    logic                  read_allow;
    int                    op_count;
    int                    done_count = 0;

    pe_clock_gen #(.PERIOD(CLK_PERIOD)) clock_gen (.clk(clk));

    pe_top DUT (
        .clk(clk), .rstn(rstn), .clear(clear), .start(start), .op(op),
        .weight_wen(weight_wen), .weight_din(weight_din), .weight_full(weight_full),
        .ifmap_wen(ifmap_wen), .ifmap_din(ifmap_din), .ifmap_full(ifmap_full),
        .psum_ren(psum_ren), .psum_dout(psum_dout), .psum_empty(psum_empty),
        .busy(busy), .done(done)
    );

    // sum of signed products wrapped to psum width
    function automatic logic [PSUM_WIDTH-1:0] psum_ref(input row_t w, input row_t px);
        int total;
        total = 0;
        for (int i = 0; i < FILT_LEN; i++) begin
            total = total + int'(w[i]) * int'(px[i]);
        end
        return PSUM_WIDTH'(total);
    endfunction

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_psum(input string name, input logic [PSUM_WIDTH-1:0] actual,
                              input logic [PSUM_WIDTH-1:0] exp);
        if (actual !== exp) begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, actual, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic exp);
        if (actual !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, actual, exp);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic load_weights();
        for (int i = 0; i < FILT_LEN; i++) begin
            weights[i] = DATA_WIDTH'($urandom);
            weight_wen = 1'b1;
            weight_din = weights[i];
            next_cycle();
        end
        weight_wen = 1'b0;
    endtask

    task automatic new_pixels();
        for (int i = 0; i < FILT_LEN; i++) begin
            pixels[i] = DATA_WIDTH'($urandom);
        end
    endtask

    // random idle gap of 0 .. max_gap cycles before each pixel
    task automatic load_pixels(input int max_gap);
        int gap;
        for (int i = 0; i < FILT_LEN; i++) begin
            gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            repeat (gap) next_cycle();
            ifmap_wen = 1'b1;
            ifmap_din = pixels[i];
            next_cycle();
            ifmap_wen = 1'b0;
        end
    endtask

    task automatic model_op(input pe_op_t code);
        acc_model = acc_model + psum_ref(weights, pixels);
        if (code == OP_MAC_EMIT) begin
            expected.push_back(acc_model);
            acc_model = '0;
        end
        op_count++;
    endtask

    task automatic start_op(input pe_op_t code);
        start = 1'b1;
        op    = code;
        next_cycle();
        start = 1'b0;
        check_flag("busy", busy, 1'b1);
    endtask

    task automatic wait_done();
        while (done !== 1'b1) next_cycle();
        check_flag("busy", busy, 1'b1);
        next_cycle();
        check_flag("done", done, 1'b0); // single cycle pulse
        check_flag("busy", busy, 1'b0);
    endtask

    task automatic do_op(input pe_op_t code, input int max_gap);
        new_pixels();
        model_op(code);
        if (max_gap == 0) begin
            load_pixels(0);
            start_op(code);
        end else begin
            start_op(code);
            load_pixels(max_gap); // controller stalls on the gaps
        end
        wait_done();
    endtask

    task automatic drain_psums();
        while (expected.size() != 0 || psum_empty !== 1'b1) next_cycle();
    endtask

    always @(negedge clk) begin
        if (rstn && done) begin
            done_count <= done_count + 1;
        end
    end

    // pops and checks one psum per cycle
    initial begin
        psum_ren = 1'b0;
        forever begin
            next_cycle();
            psum_ren = 1'b0;
            if (rstn && read_allow && !psum_empty) begin
                if (expected.size() == 0) begin
                    $display("a psum came out while none was expected");
                    abort_run();
                end else begin
                    check_psum("psum_dout", psum_dout, expected.pop_front());
                    psum_ren = 1'b1;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired before all tests completed");
        abort_run();
    end

    initial begin
        void'($urandom(73));
        rstn       = 1'b0;
        clear      = 1'b0;
        start      = 1'b0;
        op         = OP_MAC;
        weight_wen = 1'b0;
        weight_din = '0;
        ifmap_wen  = 1'b0;
        ifmap_din  = '0;
        read_allow = 1'b1;
        acc_model  = '0;
        op_count   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rstn = 1'b1;

        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("psum_empty", psum_empty, 1'b1);
        check_flag("weight_full", weight_full, 1'b0);
        check_flag("ifmap_full", ifmap_full, 1'b0);

        // single emit over one row
        load_weights();
        check_flag("weight_full", weight_full, 1'b1);
        do_op(OP_MAC_EMIT, 0);
        check_flag("psum_empty", psum_empty, 1'b0); // psum lands after done
        drain_psums();

        // accumulate over several ops with the same row
        repeat (3) do_op(OP_MAC, 0);
        do_op(OP_MAC_EMIT, 0);
        check_flag("weight_full", weight_full, 1'b1);
        drain_psums();

        // pixels trickle in during the operation
        repeat (2) do_op(OP_MAC, FILT_LEN);
        do_op(OP_MAC_EMIT, FILT_LEN);
        drain_psums();

        // a full psum buffer holds the next emit until a read
        read_allow = 1'b0;
        repeat (PSUM_DEPTH) do_op(OP_MAC_EMIT, 0);
        check_flag("psum_empty", psum_empty, 1'b0);
        new_pixels();
        model_op(OP_MAC_EMIT);
        load_pixels(0);
        start_op(OP_MAC_EMIT);
        repeat (6) begin
            next_cycle();
            check_flag("busy", busy, 1'b1);
            check_flag("done", done, 1'b0);
        end
        read_allow = 1'b1;
        wait_done();
        drain_psums();

        // clear drops the stored psum, the pending sum, the pixels and the filter row
        read_allow = 1'b0;
        do_op(OP_MAC_EMIT, 0); // psum left in the buffer
        do_op(OP_MAC, 0);      // pending sum in the accumulator
        ifmap_wen = 1'b1;
        repeat (IFMAP_DEPTH) begin
            ifmap_din = DATA_WIDTH'($urandom);
            next_cycle();
        end
        ifmap_wen = 1'b0;
        check_flag("psum_empty", psum_empty, 1'b0);
        check_flag("ifmap_full", ifmap_full, 1'b1);
        clear = 1'b1;
        next_cycle();
        clear = 1'b0;
        acc_model = '0;
        expected.delete();
        read_allow = 1'b1;
        check_flag("psum_empty", psum_empty, 1'b1);
        check_flag("ifmap_full", ifmap_full, 1'b0);
        check_flag("weight_full", weight_full, 1'b0);
        load_weights();
        do_op(OP_MAC_EMIT, 0);
        drain_psums();

        if (done_count != op_count) begin
            $display("saw %0d done pulses for %0d operations", done_count, op_count);
            abort_run();
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

//--- pe_top.sv
module pe_top (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              clear,
    input  logic                              start,
    input  pe_ctrl_pkg::pe_op_t               op,
    input  logic                              weight_wen,
    input  logic [pe_cfg_pkg::DATA_WIDTH-1:0] weight_din,
    output logic                              weight_full,
    input  logic                              ifmap_wen,
    input  logic [pe_cfg_pkg::DATA_WIDTH-1:0] ifmap_din,
    output logic                              ifmap_full,
    input  logic                              psum_ren,
    output logic [pe_cfg_pkg::PSUM_WIDTH-1:0] psum_dout,
    output logic                              psum_empty,
    output logic                              busy,
    output logic                              done
);

    import pe_cfg_pkg::*;

    logic                  filt_wen;
    logic [DATA_WIDTH-1:0] filt_din;
    logic                  filt_ren;
    logic [DATA_WIDTH-1:0] filt_dout;
    logic                  ifmap_ren;
    logic [DATA_WIDTH-1:0] ifmap_dout;
    logic                  ifmap_empty;
    logic                  issue;
    logic                  emit;
    logic [PSUM_WIDTH-1:0] product;
    logic                  prod_valid;
    logic                  prod_emit;
    logic                  psum_full;

    wire clear_idle = clear && !busy; // clear ignored mid-operation

    fifo_buffer #(
        .WIDTH(DATA_WIDTH),
        .DEPTH(FILT_LEN)
    ) filter_buffer (
        .clk  (clk),
        .rstn (rstn),
        .clear(clear_idle),
        .wen  (filt_wen),
        .ren  (filt_ren),
        .din  (filt_din),
        .dout (filt_dout),
        .full (weight_full),
        .empty()
    );

    fifo_buffer #(
        .WIDTH(DATA_WIDTH),
        .DEPTH(IFMAP_DEPTH)
    ) ifmap_buffer (
        .clk  (clk),
        .rstn (rstn),
        .clear(clear_idle),
        .wen  (ifmap_wen),
        .ren  (ifmap_ren),
        .din  (ifmap_din),
        .dout (ifmap_dout),
        .full (ifmap_full),
        .empty(ifmap_empty)
    );

    pe_controller u_controller (
        .clk(clk), .rstn(rstn), .start(start), .op(op),
        .ifmap_empty(ifmap_empty), .psum_full(psum_full),
        .weight_wen(weight_wen), .weight_din(weight_din), .filt_dout(filt_dout),
        .filt_wen(filt_wen), .filt_din(filt_din), .filt_ren(filt_ren),
        .ifmap_ren(ifmap_ren), .issue(issue), .emit(emit), .busy(busy), .done(done)
    );

    mac_unit u_mac (
        .clk(clk), .rstn(rstn), .clear(clear_idle), .issue(issue), .emit(emit),
        .weight(filt_dout), .pixel(ifmap_dout),
        .product(product), .prod_valid(prod_valid), .prod_emit(prod_emit)
    );

    psum_scratch_pad u_psum (
        .clk(clk), .rstn(rstn), .clear(clear_idle),
        .product(product), .prod_valid(prod_valid), .prod_emit(prod_emit),
        .psum_ren(psum_ren), .psum_dout(psum_dout),
        .psum_full(psum_full), .psum_empty(psum_empty)
    );

endmodule

//--- psum_scratch_pad.sv
module psum_scratch_pad (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              clear,
    input  logic [pe_cfg_pkg::PSUM_WIDTH-1:0] product,
    input  logic                              prod_valid,
    input  logic                              prod_emit,
    input  logic                              psum_ren,
    output logic [pe_cfg_pkg::PSUM_WIDTH-1:0] psum_dout,
    output logic                              psum_full,
    output logic                              psum_empty
);

    import pe_cfg_pkg::*;

    logic [PSUM_WIDTH-1:0] acc;     // held partial sum
    logic [PSUM_WIDTH-1:0] acc_sum;
    logic                  release_psum;

    assign acc_sum      = acc + product; // wraps at psum width
    assign release_psum = prod_valid && prod_emit;

    // hold the running sum; on emit the final sum leaves and acc restarts
    always_ff @(posedge clk) begin
        if (!rstn) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (prod_valid) begin
            if (prod_emit) begin
                acc <= '0;
            end else begin
                acc <= acc_sum;
            end
        end
    end

    fifo_buffer #(
        .WIDTH(PSUM_WIDTH),
        .DEPTH(PSUM_DEPTH)
    ) psum_buffer (
        .clk  (clk),
        .rstn (rstn),
        .clear(clear),
        .wen  (release_psum), // same edge as the last add
        .ren  (psum_ren),
        .din  (acc_sum),
        .dout (psum_dout),
        .full (psum_full),
        .empty(psum_empty)
    );

endmodule
